/* logic/bank_array.sv */
`timescale 1ns/1ps

module bank_array (
  input  logic                                     clk,
  input  mp_pkg::bank_cmd_t [mp_pkg::NUM_PBNK-1:0] bank_cmd,
  output mp_pkg::data_t     [mp_pkg::NUM_PBNK-1:0] bank_rdata
);

  // One single-port array per physical bank
  for (genvar b = 0; b < mp_pkg::NUM_PBNK; b++) begin : g_bank
    mp_pkg::data_t mem [mp_pkg::NUM_ROW];

    always_ff @(posedge clk) begin
      if (bank_cmd[b].en) begin
        if (bank_cmd[b].we) begin
          mem[bank_cmd[b].row] <= bank_cmd[b].data;
        end else begin
          bank_rdata[b] <= mem[bank_cmd[b].row];  // Held until next read
        end
      end
    end
  end

endmodule

/* logic/bank_map.sv */
`timescale 1ns/1ps

module bank_map (
  input  logic                clk,
  input  logic                rst_n,
  input  mp_pkg::row_t  [1:0] rd_row,
  input  mp_pkg::vbnk_t [1:0] rd_vbnk,
  output mp_pkg::pbnk_t [1:0] rd_pbnk,
  input  mp_pkg::row_t        wr_row,
  input  mp_pkg::vbnk_t       wr_vbnk,
  output mp_pkg::pbnk_t       wr_pbnk,
  output mp_pkg::pbnk_t       wr_free,
  input  logic                remap_we
);

  // Physical home of every virtual bank, per row
  mp_pkg::pbnk_t [mp_pkg::NUM_VBNK-1:0] home [mp_pkg::NUM_ROW];
  mp_pkg::pbnk_t                        free_bnk [mp_pkg::NUM_ROW];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < mp_pkg::NUM_ROW; r++) begin
        for (int v = 0; v < mp_pkg::NUM_VBNK; v++) begin
          home[r][v] <= mp_pkg::pbnk_t'(v);  // Identity map
        end
        free_bnk[r] <= mp_pkg::pbnk_t'(mp_pkg::NUM_PBNK - 1);
      end
    end else if (remap_we) begin
      // Swap home and free bank for the redirected word
      home[wr_row][wr_vbnk] <= free_bnk[wr_row];
      free_bnk[wr_row]      <= home[wr_row][wr_vbnk];
    end
  end

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      rd_pbnk[p] = home[rd_row[p]][rd_vbnk[p]];
    end
  end

  assign wr_pbnk = home[wr_row][wr_vbnk];
  assign wr_free = free_bnk[wr_row];  // Never a home within this row

endmodule

/* logic/mp_2r1w_top.sv */
`timescale 1ns/1ps

module mp_2r1w_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic              [1:0]  rd_push,
  input  mp_pkg::rd_req_t   [1:0]  rd_req,
  output logic              [1:0]  rd_credit,
  input  logic                     wr_push,
  input  mp_pkg::wr_req_t          wr_req,
  output logic                     wr_credit,
  output mp_pkg::rd_rsp_t   [1:0]  rd_rsp
);

  mp_pkg::rd_req_t   [1:0]                  rd_head;
  logic              [1:0]                  rd_nonempty;
  mp_pkg::wr_req_t                          wr_head;
  logic                                     wr_nonempty;
  mp_pkg::row_t      [1:0]                  rd_row;
  mp_pkg::vbnk_t     [1:0]                  rd_vbnk;
  mp_pkg::pbnk_t     [1:0]                  rd_pbnk;
  mp_pkg::row_t                             wr_row;
  mp_pkg::vbnk_t                            wr_vbnk;
  mp_pkg::pbnk_t                            wr_pbnk;
  mp_pkg::pbnk_t                            wr_free;
  logic                                     remap_we;
  mp_pkg::bank_cmd_t [mp_pkg::NUM_PBNK-1:0] bank_cmd;
  mp_pkg::data_t     [mp_pkg::NUM_PBNK-1:0] bank_rdata;

  // Pops double as credit returns
  for (genvar p = 0; p < 2; p++) begin : g_rd_q
    req_queue #(
      .payload_t (mp_pkg::rd_req_t),
      .DEPTH     (mp_pkg::QDEPTH)
    ) i_rd_queue (
      .clk      (clk),
      .rst_n    (rst_n),
      .push     (rd_push[p]),
      .din      (rd_req[p]),
      .pop      (rd_credit[p]),
      .head     (rd_head[p]),
      .nonempty (rd_nonempty[p])
    );
  end

  req_queue #(
    .payload_t (mp_pkg::wr_req_t),
    .DEPTH     (mp_pkg::QDEPTH)
  ) i_wr_queue (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (wr_push),
    .din      (wr_req),
    .pop      (wr_credit),
    .head     (wr_head),
    .nonempty (wr_nonempty)
  );

  bank_map i_bank_map (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_row   (rd_row),
    .rd_vbnk  (rd_vbnk),
    .rd_pbnk  (rd_pbnk),
    .wr_row   (wr_row),
    .wr_vbnk  (wr_vbnk),
    .wr_pbnk  (wr_pbnk),
    .wr_free  (wr_free),
    .remap_we (remap_we)
  );

  port_sched i_port_sched (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_head     (rd_head),
    .rd_nonempty (rd_nonempty),
    .rd_pop      (rd_credit),
    .wr_head     (wr_head),
    .wr_nonempty (wr_nonempty),
    .wr_pop      (wr_credit),
    .rd_row      (rd_row),
    .rd_vbnk     (rd_vbnk),
    .rd_pbnk     (rd_pbnk),
    .wr_row      (wr_row),
    .wr_vbnk     (wr_vbnk),
    .wr_pbnk     (wr_pbnk),
    .wr_free     (wr_free),
    .remap_we    (remap_we),
    .bank_cmd    (bank_cmd),
    .bank_rdata  (bank_rdata),
    .rd_rsp      (rd_rsp)
  );

  bank_array i_bank_array (
    .clk        (clk),
    .bank_cmd   (bank_cmd),
    .bank_rdata (bank_rdata)
  );

endmodule

/* logic/mp_pkg.sv */
package mp_pkg;

  localparam int DATA_W   = 16;
  localparam int NUM_VBNK = 4;
  localparam int NUM_PBNK = NUM_VBNK + 1;  // Four data banks plus the spare
  localparam int NUM_ROW  = 16;
  localparam int ADDR_W   = 6;
  localparam int VBNK_W   = $clog2(NUM_VBNK);
  localparam int ROW_W    = ADDR_W - VBNK_W;
  localparam int PBNK_W   = 3;
  localparam int QDEPTH   = 4;             // Also the initial credit count

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ROW_W-1:0]  row_t;
  typedef logic [VBNK_W-1:0] vbnk_t;
  typedef logic [PBNK_W-1:0] pbnk_t;

  // Low address bits pick the virtual bank, high bits the row
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    data_t             data;
  } wr_req_t;

  typedef struct packed {
    logic  en;
    logic  we;
    row_t  row;
    data_t data;
  } bank_cmd_t;

  typedef struct packed {
    logic  vld;
    data_t data;
  } rd_rsp_t;

endpackage

/* logic/port_sched.sv */
`timescale 1ns/1ps

module port_sched (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  mp_pkg::rd_req_t   [1:0]                      rd_head,
  input  logic              [1:0]                      rd_nonempty,
  output logic              [1:0]                      rd_pop,
  input  mp_pkg::wr_req_t                              wr_head,
  input  logic                                         wr_nonempty,
  output logic                                         wr_pop,
  output mp_pkg::row_t      [1:0]                      rd_row,
  output mp_pkg::vbnk_t     [1:0]                      rd_vbnk,
  input  mp_pkg::pbnk_t     [1:0]                      rd_pbnk,
  output mp_pkg::row_t                                 wr_row,
  output mp_pkg::vbnk_t                                wr_vbnk,
  input  mp_pkg::pbnk_t                                wr_pbnk,
  input  mp_pkg::pbnk_t                                wr_free,
  output logic                                         remap_we,
  output mp_pkg::bank_cmd_t [mp_pkg::NUM_PBNK-1:0]     bank_cmd,
  input  mp_pkg::data_t     [mp_pkg::NUM_PBNK-1:0]     bank_rdata,
  output mp_pkg::rd_rsp_t   [1:0]                      rd_rsp
);

  logic                rd1_clash;
  logic                wr_cur_busy;
  logic                wr_free_busy;
  mp_pkg::pbnk_t       wr_bnk;
  logic [1:0]          rsp_vld_q;
  mp_pkg::pbnk_t [1:0] rsp_bnk_q;

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      rd_row[p]  = rd_head[p].addr[mp_pkg::ADDR_W-1:mp_pkg::VBNK_W];
      rd_vbnk[p] = rd_head[p].addr[mp_pkg::VBNK_W-1:0];
    end
  end

  assign wr_row  = wr_head.addr[mp_pkg::ADDR_W-1:mp_pkg::VBNK_W];
  assign wr_vbnk = wr_head.addr[mp_pkg::VBNK_W-1:0];

  // Port 0 always wins, port 1 only on a different bank
  assign rd1_clash  = rd_nonempty[0] && (rd_pbnk[1] == rd_pbnk[0]);
  assign rd_pop[0]  = rd_nonempty[0];
  assign rd_pop[1]  = rd_nonempty[1] && !rd1_clash;

  assign wr_cur_busy  = (rd_pop[0] && (rd_pbnk[0] == wr_pbnk)) ||
                        (rd_pop[1] && (rd_pbnk[1] == wr_pbnk));
  assign wr_free_busy = (rd_pop[0] && (rd_pbnk[0] == wr_free)) ||
                        (rd_pop[1] && (rd_pbnk[1] == wr_free));

  // Write stalls only when home and spare are both taken
  assign wr_pop   = wr_nonempty && !(wr_cur_busy && wr_free_busy);
  assign remap_we = wr_pop && wr_cur_busy;
  assign wr_bnk   = wr_cur_busy ? wr_free : wr_pbnk;

  always_comb begin
    for (int b = 0; b < mp_pkg::NUM_PBNK; b++) begin
      bank_cmd[b]      = '0;
      bank_cmd[b].data = wr_head.data;
      if (wr_pop && (wr_bnk == mp_pkg::pbnk_t'(b))) begin
        bank_cmd[b].en  = 1'b1;
        bank_cmd[b].we  = 1'b1;
        bank_cmd[b].row = wr_row;
      end else if (rd_pop[0] && (rd_pbnk[0] == mp_pkg::pbnk_t'(b))) begin
        bank_cmd[b].en  = 1'b1;
        bank_cmd[b].row = rd_row[0];
      end else if (rd_pop[1] && (rd_pbnk[1] == mp_pkg::pbnk_t'(b))) begin
        bank_cmd[b].en  = 1'b1;
        bank_cmd[b].row = rd_row[1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_vld_q <= '0;
    end else begin
      rsp_vld_q <= rd_pop;
    end
  end

  always_ff @(posedge clk) begin
    rsp_bnk_q <= rd_pbnk;  // Serving bank, used one cycle later
  end

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      rd_rsp[p].vld  = rsp_vld_q[p];
      rd_rsp[p].data = bank_rdata[rsp_bnk_q[p]];
    end
  end

endmodule

/* logic/req_queue.sv */
`timescale 1ns/1ps

module req_queue #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = mp_pkg::QDEPTH
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t head,
  output logic     nonempty
);

  payload_t                   mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       do_push;
  logic                       do_pop;

  assign do_push = push && (count != DEPTH);  // Overflow push dropped
  assign do_pop  = pop && (count != 0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  assign head     = mem[rd_ptr];
  assign nonempty = (count != 0);

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
# $fatal in the testbench gives a nonzero exit status from the simulator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_mp_2r1w \
    -f sim.f -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vtb_mp_2r1w; then
  echo "Simulation ended with an error status"
  exit 1
fi

echo "Simulation ended normally"
exit 0

/* sim.f */
logic/mp_pkg.sv
logic/req_queue.sv
logic/bank_map.sv
logic/port_sched.sv
logic/bank_array.sv
logic/mp_2r1w_top.sv
test/tb_mp_2r1w.sv

/* test/mp_stimulus.txt */
# op r0_en r0_addr r0_exp r1_en r1_addr r1_exp w_en w_addr w_data (all hex)
# op 0 random gap, 1 fence, 2 back to back, 3 fence and fill all, 4 fence and read back all
3 0 00 0000 0 00 0000 1 00 0000
4 0 00 0000 0 00 0000 0 00 0000
# Known values in virtual bank 0, rows 0 to 3
2 0 00 0000 0 00 0000 1 00 1000
2 0 00 0000 0 00 0000 1 04 1004
2 0 00 0000 0 00 0000 1 08 1008
2 0 00 0000 0 00 0000 1 0c 100c
# Both ports on physical bank 0
1 1 00 1000 1 04 1004 0 00 0000
2 1 08 1008 1 0c 100c 0 00 0000
2 1 04 1004 1 00 1000 0 00 0000
2 1 0c 100c 1 08 1008 0 00 0000
2 1 00 1000 1 08 1008 0 00 0000
# Rows 1, 2, 3 and 4
2 0 00 0000 0 00 0000 1 05 2005
2 0 00 0000 0 00 0000 1 06 2006
2 0 00 0000 0 00 0000 1 09 2009
2 0 00 0000 0 00 0000 1 0a 200a
2 0 00 0000 0 00 0000 1 0b 200b
2 0 00 0000 0 00 0000 1 0d 200d
2 0 00 0000 0 00 0000 1 11 2011
# Write home busy with a read, word moves to the spare
1 1 05 2005 0 00 0000 1 09 3009
1 1 06 2006 0 00 0000 1 0a 300a
# Home and spare both busy, write waits a cycle
1 1 09 3009 1 05 2005 1 11 3011
1 1 08 1008 1 09 3009 0 00 0000
2 1 0a 300a 1 0b 200b 0 00 0000
2 1 11 3011 1 0d 200d 0 00 0000
# Mixed traffic, writes and reads never share an address
0 1 00 1000 1 09 3009 1 20 4020
0 1 0a 300a 0 00 0000 1 21 4021
0 0 00 0000 1 0b 200b 1 22 4022
0 1 04 1004 1 05 2005 1 23 4023
0 1 11 3011 1 06 2006 1 24 4024
0 1 0c 100c 1 08 1008 1 25 4025
1 1 20 4020 1 21 4021 0 00 0000
0 1 22 4022 1 23 4023 0 00 0000
0 1 24 4024 1 25 4025 0 00 0000
# Final sweep over the remapped rows
4 0 00 0000 0 00 0000 0 00 0000

/* test/tb_mp_2r1w.sv */
`timescale 1ns/1ps

module tb_mp_2r1w;

  typedef struct packed {
    logic [2:0]               op;
    logic                     r0_en;
    logic [mp_pkg::ADDR_W-1:0] r0_addr;
    mp_pkg::data_t            r0_exp;
    logic                     r1_en;
    logic [mp_pkg::ADDR_W-1:0] r1_addr;
    mp_pkg::data_t            r1_exp;
    logic                     w_en;
    logic [mp_pkg::ADDR_W-1:0] w_addr;
    mp_pkg::data_t            w_data;
  } stim_t;

  logic                  clk;
  logic                  rst_n;
  logic            [1:0] rd_push;
  mp_pkg::rd_req_t [1:0] rd_req;
  logic            [1:0] rd_credit;
  logic                  wr_push;
  mp_pkg::wr_req_t       wr_req;
  logic                  wr_credit;
  mp_pkg::rd_rsp_t [1:0] rd_rsp;

  stim_t         stim [64];
  int            n_lines;
  mp_pkg::data_t model [64];
  mp_pkg::data_t exp_data [2][256];  // Expected read data per port, in push order
  int            exp_put [2];
  int            exp_get [2];
  int            rd_sent [2];
  int            rd_back [2];
  int            wr_sent;
  int            wr_back;
  int            cycle_cnt = 0;
  int            cycle_limit;

  mp_2r1w_top i_mp_2r1w_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_push   (rd_push),
    .rd_req    (rd_req),
    .rd_credit (rd_credit),
    .wr_push   (wr_push),
    .wr_req    (wr_req),
    .wr_credit (wr_credit),
    .rd_rsp    (rd_rsp)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("error %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic mp_pkg::data_t fill_pattern(input logic [5:0] a);
    return {a, a[3:0], a};  // Every address bit shows up
  endfunction

  function automatic bit credit_ok(input logic [1:0] rd_en, input logic w_en);
    bit ok;
    ok = 1'b1;
    for (int p = 0; p < 2; p++) begin
      if (rd_en[p] && (rd_sent[p] - rd_back[p] >= mp_pkg::QDEPTH)) begin
        ok = 1'b0;
      end
    end
    if (w_en && (wr_sent - wr_back >= mp_pkg::QDEPTH)) begin
      ok = 1'b0;
    end
    return ok;
  endfunction

  function automatic bit credits_home();
    return (rd_sent[0] == rd_back[0]) && (rd_sent[1] == rd_back[1]) && (wr_sent == wr_back);
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_credits();
    while (!credits_home()) begin
      next_cycle();
    end
  endtask

  // Pushes one line in a single cycle, waiting for credits first
  task automatic issue_op(input logic [1:0] rd_en, input logic [5:0] a0, input logic [5:0] a1,
                          input logic w_en, input logic [5:0] wa, input mp_pkg::data_t wd);
    logic [5:0] ra [2];
    ra[0] = a0;
    ra[1] = a1;
    while (!credit_ok(rd_en, w_en)) begin
      next_cycle();
    end
    for (int p = 0; p < 2; p++) begin
      rd_req[p].addr = ra[p];
      if (rd_en[p]) begin
        exp_data[p][exp_put[p] % 256] = model[ra[p]];
        exp_put[p]++;
        rd_sent[p]++;
      end
    end
    rd_push     = rd_en;
    wr_push     = w_en;
    wr_req.addr = wa;
    wr_req.data = wd;
    if (w_en) begin
      model[wa] = wd;
      wr_sent++;
    end
    next_cycle();
    rd_push = '0;
    wr_push = 1'b0;
  endtask

  task automatic read_stimulus();
    int    fd;
    int    n;
    string line;
    int    f_op, f_r0e, f_r0a, f_r0x, f_r1e;
    int    f_r1a, f_r1x, f_we, f_wa, f_wd;
    fd = $fopen("test/mp_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the stimulus file test/mp_stimulus.txt");
    end
    n_lines = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if ((n > 0) && (line.substr(0, 0) != "#")) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f_op, f_r0e, f_r0a, f_r0x,
                    f_r1e, f_r1a, f_r1x, f_we, f_wa, f_wd);
        if ((n == 10) && (f_op <= 4) && (n_lines < 64)) begin
          stim[n_lines].op      = 3'(f_op);
          stim[n_lines].r0_en   = 1'(f_r0e);
          stim[n_lines].r0_addr = 6'(f_r0a);
          stim[n_lines].r0_exp  = 16'(f_r0x);
          stim[n_lines].r1_en   = 1'(f_r1e);
          stim[n_lines].r1_addr = 6'(f_r1a);
          stim[n_lines].r1_exp  = 16'(f_r1x);
          stim[n_lines].w_en    = 1'(f_we);
          stim[n_lines].w_addr  = 6'(f_wa);
          stim[n_lines].w_data  = 16'(f_wd);
          n_lines++;
        end else if (n > 0) begin
          abort_run($sformatf("stimulus line not understood: %s", line));
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_line(input stim_t s);
    case (s.op)
      3'd0: repeat ($urandom_range(2)) next_cycle();
      3'd1: wait_credits();
      3'd3: begin
        wait_credits();
        for (int a = 0; a < 64; a++) begin
          issue_op(2'b00, '0, '0, 1'b1, 6'(a), s.w_data ^ fill_pattern(6'(a)));
        end
      end
      3'd4: begin
        wait_credits();
        for (int a = 0; a < 64; a++) begin
          issue_op(2'b11, 6'(a), 6'(63 - a), 1'b0, '0, '0);
        end
      end
      default: ;
    endcase
    if (s.op <= 3'd2) begin
      // File values must agree with the model
      if (s.r0_en) check_value("stimulus r0_exp", 32'(s.r0_exp), 32'(model[s.r0_addr]));
      if (s.r1_en) check_value("stimulus r1_exp", 32'(s.r1_exp), 32'(model[s.r1_addr]));
      issue_op({s.r1_en, s.r0_en}, s.r0_addr, s.r1_addr, s.w_en, s.w_addr, s.w_data);
    end
  endtask

  // Outputs settle by the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      for (int p = 0; p < 2; p++) begin
        exp_get[p] = 0;
        rd_back[p] = 0;
      end
      wr_back = 0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (rd_rsp[p].vld) begin
          if (exp_get[p] == exp_put[p]) begin
            abort_run($sformatf("read port %0d returned data with no read outstanding", p));
          end
          check_value($sformatf("rd_rsp[%0d].data", p), 32'(rd_rsp[p].data),
                      32'(exp_data[p][exp_get[p] % 256]));
          exp_get[p]++;
        end
        if (rd_credit[p]) rd_back[p]++;
      end
      if (wr_credit) wr_back++;
      if ((rd_back[0] > rd_sent[0]) || (rd_back[1] > rd_sent[1]) || (wr_back > wr_sent)) begin
        abort_run("a credit came back for a request that was never pushed");
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      abort_run($sformatf("timeout after %0d cycles, traffic did not drain", cycle_cnt));
    end
  end

  initial begin
    int ops;
    void'($urandom(50177));
    clk     = 1'b0;
    rst_n   = 1'b0;
    rd_push = '0;
    rd_req  = '0;
    wr_push = 1'b0;
    wr_req  = '0;
    wr_sent = 0;
    for (int p = 0; p < 2; p++) begin
      exp_put[p] = 0;
      rd_sent[p] = 0;
    end
    for (int a = 0; a < 64; a++) begin
      model[a] = '0;
    end
    read_stimulus();
    ops = 0;
    for (int i = 0; i < n_lines; i++) begin
      ops += (stim[i].op >= 3'd3) ? 64 : 1;  // Sweeps issue one op per address
    end
    cycle_limit = 20 * ops + 200;

    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle after reset
    repeat (8) begin
      @(negedge clk);
      for (int p = 0; p < 2; p++) begin
        check_value($sformatf("rd_rsp[%0d].vld", p), 32'(rd_rsp[p].vld), 32'd0);
        check_value($sformatf("rd_credit[%0d]", p), 32'(rd_credit[p]), 32'd0);
      end
      check_value("wr_credit", 32'(wr_credit), 32'd0);
    end
    next_cycle();

    for (int i = 0; i < n_lines; i++) begin
      run_line(stim[i]);
    end

    // Drain on read data and write credits
    while ((exp_get[0] != exp_put[0]) || (exp_get[1] != exp_put[1]) ||
           (wr_back != wr_sent)) begin
      next_cycle();
    end
    repeat (4) next_cycle();

    // Every returned read must also have returned its credit
    check_value("rd_credit[0] count", rd_back[0], rd_sent[0]);
    check_value("rd_credit[1] count", rd_back[1], rd_sent[1]);
    $display("All checks passed");
    $finish;
  end

endmodule
